/* source/zxmem_consts.svh */
`ifndef ZXMEM_CONSTS_SVH
`define ZXMEM_CONSTS_SVH

// ZXUNO register numbers
`define ZX_MASTERCONF     8'h00
`define ZX_MASTERMAPPER   8'h01

// Partial decode of the 128K and +3 paging ports
`define ZX_PORT_7FFD_MASK 16'hC003
`define ZX_PORT_7FFD_VAL  16'h4001   // A15=0 A14=1 A1=0 A0=1
`define ZX_PORT_1FFD_MASK 16'hF003
`define ZX_PORT_1FFD_VAL  16'h1001   // A15..13=000 A12=1 A1=0 A0=1
`define ZX_DIVMMC_PORT    8'hE3

// Automapper entry points, paged after the opcode fetch
`define ZX_AM_ENTRY_RST0  16'h0000
`define ZX_AM_ENTRY_RST8  16'h0008
`define ZX_AM_ENTRY_RST38 16'h0038
`define ZX_AM_ENTRY_NMI   16'h0066
`define ZX_AM_ENTRY_LOAD  16'h04C6
`define ZX_AM_ENTRY_SAVE  16'h0562
`define ZX_AM_PAGE_NOW    8'h3D      // Paged during the fetch itself
`define ZX_AM_UNMAP       13'h03FF   // 1FF8-1FFF, A15..A3

// SRAM region bases, upper address bits
`define ZX_BASE_ROM       3'b010
`define ZX_BASE_DIVROM    6'b011000
`define ZX_BASE_DIVRAM    2'b10

`endif

/* source/zxmem_pkg.sv */
`default_nettype none

package zxmem_pkg;

   // One CPU bus cycle as seen on the pins
   typedef struct packed {
      logic [15:0] a;
      logic [7:0]  din;
      logic        mreq_n;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
      logic        m1_n;
   } cpu_bus_t;

   // Decoded cycle, one flag per kind of access
   typedef struct packed {
      logic mem_rd;
      logic mem_wr;
      logic fetch;            // M1 opcode read
      logic wr_7ffd;
      logic wr_1ffd;
      logic wr_e3;
      logic wr_masterconf;
      logic wr_mastermapper;
      logic rd_masterconf;
      logic rd_mastermapper;
   } cycle_t;

   typedef struct packed {
      logic       boot_mode;
      logic       divmmc_enabled;
      logic       divmmc_nmi_disabled;
      logic [4:0] mastermapper;
      logic [7:0] bank128;
      logic [7:0] bankplus3;
      logic [7:0] divmmc_ctrl;
   } paging_t;

   typedef struct packed {
      logic [18:0] sram_addr;
      logic        sram_we;      // Writable page in a memory cycle
      logic        ram_oe;
      logic        bootrom_oe;
   } map_t;

endpackage

`default_nettype wire

/* source/cpu_cycle_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zxmem_consts.svh"

module cpu_cycle_decode (
   input  wire zxmem_pkg::cpu_bus_t bus,
   input  wire [7:0]                zx_addr,
   input  wire                      zx_ior,
   input  wire                      zx_iow,
   output zxmem_pkg::cycle_t        cyc
);

   logic io_wr;
   logic match_7ffd;
   logic match_1ffd;

   assign io_wr      = !bus.iorq_n && !bus.wr_n;
   assign match_7ffd = (bus.a & `ZX_PORT_7FFD_MASK) == `ZX_PORT_7FFD_VAL;
   assign match_1ffd = (bus.a & `ZX_PORT_1FFD_MASK) == `ZX_PORT_1FFD_VAL;

   always_comb begin
      cyc = '0;
      // Memory side
      cyc.mem_rd = !bus.mreq_n && !bus.rd_n;
      cyc.mem_wr = !bus.mreq_n && !bus.wr_n;
      cyc.fetch  = !bus.mreq_n && !bus.rd_n && !bus.m1_n;

      // Z80 I/O ports
      cyc.wr_7ffd = io_wr && match_7ffd;
      cyc.wr_1ffd = io_wr && match_1ffd;
      cyc.wr_e3   = io_wr && (bus.a[7:0] == `ZX_DIVMMC_PORT);

      // ZXUNO register file
      cyc.wr_masterconf   = zx_iow && (zx_addr == `ZX_MASTERCONF);
      cyc.wr_mastermapper = zx_iow && (zx_addr == `ZX_MASTERMAPPER);
      cyc.rd_masterconf   = zx_ior && (zx_addr == `ZX_MASTERCONF);
      cyc.rd_mastermapper = zx_ior && (zx_addr == `ZX_MASTERMAPPER);
   end

endmodule

`default_nettype wire

/* source/paging_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module paging_regs (
   input  wire                    clk,
   input  wire                    mrst_n,
   input  wire                    rst_n,
   input  wire zxmem_pkg::cycle_t cyc,
   input  wire [7:0]              din,
   output zxmem_pkg::paging_t     pg,
   output wire                    issue2_keyboard,
   output wire                    timing_ula
);

   logic [4:0] masterconf;     // timing, issue2, nmi off, divmmc on, boot
   logic [4:0] mastermapper;
   logic [7:0] bank128;
   logic [7:0] bankplus3;
   logic [7:0] divmmc_ctrl;
   logic       ports_locked;

   assign ports_locked = bank128[5];

   //////////////////////////////////////////////////
   // ZXUNO registers, master reset only

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         masterconf <= 5'b00001;          // Start in boot mode
      end else if (cyc.wr_masterconf) begin
         masterconf <= din[4:0];
      end
   end

   // The mapper is only reachable from the boot firmware
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         mastermapper <= 5'd0;
      end else if (cyc.wr_mastermapper && masterconf[0]) begin
         mastermapper <= din[4:0];
      end
   end

   //////////////////////////////////////////////////
   // Spectrum paging ports, cleared by both resets

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         bank128   <= 8'h00;
         bankplus3 <= 8'h00;
      end else if (!ports_locked) begin
         if (cyc.wr_7ffd) begin
            bank128 <= din;
         end else if (cyc.wr_1ffd) begin
            bankplus3 <= din;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         divmmc_ctrl <= 8'h00;
      end else if (cyc.wr_e3) begin
         divmmc_ctrl <= din;           // conmem, mapram, page
      end
   end

   always_comb begin
      pg.boot_mode           = masterconf[0];
      pg.divmmc_enabled      = masterconf[1];
      pg.divmmc_nmi_disabled = masterconf[2];
      pg.mastermapper        = mastermapper;
      pg.bank128             = bank128;
      pg.bankplus3           = bankplus3;
      pg.divmmc_ctrl         = divmmc_ctrl;
   end

   assign issue2_keyboard = masterconf[3];
   assign timing_ula      = masterconf[4];

endmodule

`default_nettype wire

/* source/divmmc_automap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zxmem_consts.svh"

module divmmc_automap (
   input  wire                     clk,
   input  wire                     mrst_n,
   input  wire                     rst_n,
   input  wire zxmem_pkg::cycle_t  cyc,
   input  wire [15:0]              a,
   input  wire zxmem_pkg::paging_t pg,
   output logic                    divmmc_paged,
   output wire                     enable_nmi
);

   logic armed;                // Paging state to apply once M1 ends
   logic entry_hit;

   // NMI entry only counts while the NMI button is allowed
   assign entry_hit = (a == `ZX_AM_ENTRY_RST0)  ||
                      (a == `ZX_AM_ENTRY_RST8)  ||
                      (a == `ZX_AM_ENTRY_RST38) ||
                      (a == `ZX_AM_ENTRY_NMI && !pg.divmmc_nmi_disabled) ||
                      (a == `ZX_AM_ENTRY_LOAD)  ||
                      (a == `ZX_AM_ENTRY_SAVE);

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         armed        <= 1'b0;
         divmmc_paged <= 1'b0;
      end else if (cyc.fetch) begin
         if (entry_hit) begin
            armed <= 1'b1;                             // Deferred entry
         end else if (a[15:8] == `ZX_AM_PAGE_NOW) begin
            armed        <= 1'b1;
            divmmc_paged <= 1'b1;                      // Immediate entry
         end else if (a[15:3] == `ZX_AM_UNMAP) begin
            armed <= 1'b0;                             // Deferred exit
         end
      end else begin
         // M1 is over, the armed state becomes the mapping
         divmmc_paged <= armed;
      end
   end

   assign enable_nmi = pg.divmmc_enabled && divmmc_paged && !pg.divmmc_nmi_disabled;

endmodule

`default_nettype wire

/* source/sram_addr_map.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zxmem_consts.svh"

module sram_addr_map (
   input  wire zxmem_pkg::cpu_bus_t bus,
   input  wire zxmem_pkg::paging_t  pg,
   input  wire                      divmmc_paged,
   output zxmem_pkg::map_t          map
);

   logic        allram;
   logic [1:0]  arrangement;
   logic        mapram;
   logic        conmem;
   logic [3:0]  div_page;
   logic [2:0]  allram_page;
   logic [18:0] addr;
   logic        sram_sel;      // Low when the boot ROM answers
   logic        writable;
   logic        mem_cyc;

   assign allram      = pg.bankplus3[0];
   assign arrangement = pg.bankplus3[2:1];
   assign div_page    = pg.divmmc_ctrl[3:0];
   assign mapram      = pg.divmmc_ctrl[6];
   assign conmem      = pg.divmmc_ctrl[7];
   assign mem_cyc     = !bus.mreq_n;

   // +3 special paging, arrangements 0 to 3 per quadrant
   always_comb begin
      case (bus.a[15:14])
         2'b00:   allram_page = (arrangement == 2'b00) ? 3'd0 : 3'd4;
         2'b01:   allram_page = (arrangement == 2'b00) ? 3'd1 :
                                (arrangement == 2'b11) ? 3'd7 : 3'd5;
         2'b10:   allram_page = (arrangement == 2'b00) ? 3'd2 : 3'd6;
         default: allram_page = (arrangement == 2'b01) ? 3'd7 : 3'd3;
      endcase
   end

   //////////////////////////////////////////////////
   // Address translation

   always_comb begin
      sram_sel = 1'b1;
      writable = 1'b1;
      addr     = '0;
      case (bus.a[15:14])
         2'b00: begin
            if (pg.boot_mode) begin
               sram_sel = 1'b0;                         // Internal boot ROM
               writable = 1'b0;
            end else if (pg.divmmc_enabled && (divmmc_paged || conmem)) begin
               if (!bus.a[13]) begin
                  writable = 1'b0;                      // ROM or mapram page 3
                  if (conmem || !mapram)
                     addr = {`ZX_BASE_DIVROM, bus.a[12:0]};
                  else
                     addr = {`ZX_BASE_DIVRAM, 4'd3, bus.a[12:0]};
               end else begin
                  addr     = {`ZX_BASE_DIVRAM, div_page, bus.a[12:0]};
                  writable = conmem || !mapram || (div_page != 4'd3);
               end
            end else if (!allram) begin
               addr     = {`ZX_BASE_ROM, pg.bankplus3[2], pg.bank128[4], bus.a[13:0]};
               writable = 1'b0;
            end else begin
               addr = {2'b00, allram_page, bus.a[13:0]};
            end
         end
         2'b01: begin
            if (pg.boot_mode || !allram)
               addr = {2'b00, 3'd5, bus.a[13:0]};
            else
               addr = {2'b00, allram_page, bus.a[13:0]};
         end
         2'b10: begin
            if (pg.boot_mode || !allram)
               addr = {2'b00, 3'd2, bus.a[13:0]};
            else
               addr = {2'b00, allram_page, bus.a[13:0]};
         end
         default: begin
            if (pg.boot_mode)
               addr = {pg.mastermapper, bus.a[13:0]};   // Any 16K page of the SRAM
            else if (!allram)
               addr = {2'b00, pg.bank128[2:0], bus.a[13:0]};
            else
               addr = {2'b00, allram_page, bus.a[13:0]};
         end
      endcase
   end

   always_comb begin
      map.sram_addr  = addr;
      map.bootrom_oe = mem_cyc && !sram_sel;
      map.ram_oe     = mem_cyc && sram_sel;
      map.sram_we    = mem_cyc && sram_sel && writable;
   end

endmodule

`default_nettype wire

/* source/cpu_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_read_mux (
   input  wire zxmem_pkg::cycle_t  cyc,
   input  wire zxmem_pkg::map_t    map,
   input  wire zxmem_pkg::paging_t pg,
   input  wire [7:0]               sram_rdata,
   input  wire [7:0]               bootrom_data,
   output logic [7:0]              dout,
   output logic                    oe_n
);

   always_comb begin
      oe_n = 1'b0;
      if (map.bootrom_oe && cyc.mem_rd) begin
         dout = bootrom_data;
      end else if (map.ram_oe && cyc.mem_rd) begin
         dout = sram_rdata;
      end else if (cyc.rd_masterconf) begin
         dout = {6'b000000, pg.divmmc_enabled, pg.boot_mode};
      end else if (cyc.rd_mastermapper) begin
         dout = {3'b000, pg.mastermapper};
      end else begin
         dout = 8'hFF;       // Nothing to drive, bus floats high
         oe_n = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* source/memory_top.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_top (
   input  wire                      clk,
   input  wire                      mrst_n,
   input  wire                      rst_n,
   input  wire zxmem_pkg::cpu_bus_t bus,
   input  wire [7:0]                zx_addr,
   input  wire                      zx_ior,
   input  wire                      zx_iow,
   input  wire [7:0]                sram_rdata,
   input  wire [7:0]                bootrom_data,
   output wire [18:0]               sram_addr,
   output wire [7:0]                sram_wdata,
   output wire                      sram_we_n,
   output wire [13:0]               bootrom_addr,
   output wire [7:0]                dout,
   output wire                      oe_n,
   output wire                      boot_mode,
   output wire                      issue2_keyboard,
   output wire                      timing_ula,
   output wire                      enable_nmi
);

   zxmem_pkg::cycle_t  cyc;
   zxmem_pkg::paging_t pg;
   zxmem_pkg::map_t    map;
   logic               divmmc_paged;

   cpu_cycle_decode i_decode (
      .bus    (bus),
      .zx_addr(zx_addr),
      .zx_ior (zx_ior),
      .zx_iow (zx_iow),
      .cyc    (cyc)
   );

   paging_regs i_regs (
      .clk            (clk),
      .mrst_n         (mrst_n),
      .rst_n          (rst_n),
      .cyc            (cyc),
      .din            (bus.din),
      .pg             (pg),
      .issue2_keyboard(issue2_keyboard),
      .timing_ula     (timing_ula)
   );

   divmmc_automap i_automap (
      .clk         (clk),
      .mrst_n      (mrst_n),
      .rst_n       (rst_n),
      .cyc         (cyc),
      .a           (bus.a),
      .pg          (pg),
      .divmmc_paged(divmmc_paged),
      .enable_nmi  (enable_nmi)
   );

   sram_addr_map i_map (
      .bus         (bus),
      .pg          (pg),
      .divmmc_paged(divmmc_paged),
      .map         (map)
   );

   cpu_read_mux i_rdmux (
      .cyc         (cyc),
      .map         (map),
      .pg          (pg),
      .sram_rdata  (sram_rdata),
      .bootrom_data(bootrom_data),
      .dout        (dout),
      .oe_n        (oe_n)
   );

   //////////////////////////////////////////////////
   // SRAM and boot ROM pins

   assign sram_addr    = map.sram_addr;
   assign sram_wdata   = bus.din;
   assign sram_we_n    = !(map.sram_we && cyc.mem_wr);   // Strobe qualified here
   assign bootrom_addr = bus.a[13:0];
   assign boot_mode    = pg.boot_mode;

endmodule

`default_nettype wire

/* tb/tb_memory_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_memory_top;

   localparam logic [3:0] OP_ZXW      = 4'd0;   // ZXUNO register write
   localparam logic [3:0] OP_ZXR      = 4'd1;   // ZXUNO register read, check oe_n and dout
   localparam logic [3:0] OP_IOW      = 4'd2;   // Z80 port write
   localparam logic [3:0] OP_RD_ADDR  = 4'd3;   // Memory read, check sram_addr
   localparam logic [3:0] OP_RD_DATA  = 4'd4;   // Memory read, check oe_n and dout
   localparam logic [3:0] OP_WR       = 4'd5;   // Memory write, check sram_we_n
   localparam logic [3:0] OP_FETCH    = 4'd6;   // M1 fetch, check sram_addr
   localparam logic [3:0] OP_WAIT_MAP = 4'd7;   // Read until sram_addr changes
   localparam logic [3:0] OP_IDLE     = 4'd8;   // Idle bus, check oe_n and sram_we_n
   localparam logic [3:0] OP_NMI      = 4'd9;   // Idle bus, check enable_nmi
   localparam logic [3:0] OP_SRST     = 4'd10;  // One cycle of soft reset
   localparam logic [3:0] OP_MEMCHK   = 4'd11;  // Compare the SRAM model contents
   localparam logic [3:0] OP_FLAGS    = 4'd12;  // Idle bus, check timing, issue2 and boot

   logic                clk = 1'b0;
   logic                mrst_n;
   logic                rst_n;
   zxmem_pkg::cpu_bus_t bus;
   logic [7:0]          zx_addr;
   logic                zx_ior;
   logic                zx_iow;
   logic [7:0]          sram_rdata;
   logic [7:0]          bootrom_data;
   logic [18:0]         sram_addr;
   logic [7:0]          sram_wdata;
   logic                sram_we_n;
   logic [13:0]         bootrom_addr;
   logic [7:0]          dout;
   logic                oe_n;
   logic                boot_mode;
   logic                issue2_keyboard;
   logic                timing_ula;
   logic                enable_nmi;

   logic [7:0]  sram_mem [0:524287];
   logic [31:0] lfsr_state = 32'hfd62_4d08;

   // +3 all-RAM pages, four quadrants per arrangement
   logic [2:0]  plus3_pages [16] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7,
                                     3'd4, 3'd5, 3'd6, 3'd3, 3'd4, 3'd7, 3'd6, 3'd3};

   string       row_name [$];
   logic [3:0]  row_op [$];
   logic [15:0] row_addr [$];
   logic [7:0]  row_data [$];
   logic [18:0] row_exp [$];

   int test_errs;
   int tests_run;
   int tests_failed;
   int total_errs;

   always #4 clk = ~clk;

   memory_top i_memory_top (
      .clk            (clk),
      .mrst_n         (mrst_n),
      .rst_n          (rst_n),
      .bus            (bus),
      .zx_addr        (zx_addr),
      .zx_ior         (zx_ior),
      .zx_iow         (zx_iow),
      .sram_rdata     (sram_rdata),
      .bootrom_data   (bootrom_data),
      .sram_addr      (sram_addr),
      .sram_wdata     (sram_wdata),
      .sram_we_n      (sram_we_n),
      .bootrom_addr   (bootrom_addr),
      .dout           (dout),
      .oe_n           (oe_n),
      .boot_mode      (boot_mode),
      .issue2_keyboard(issue2_keyboard),
      .timing_ula     (timing_ula),
      .enable_nmi     (enable_nmi)
   );

   //////////////////////////////////////////////////
   // SRAM and boot ROM models

   assign sram_rdata   = sram_mem[sram_addr];
   assign bootrom_data = bootrom_addr[7:0] ^ 8'hA5;

   always @(posedge clk) begin
      if (!sram_we_n)
         sram_mem[sram_addr] <= sram_wdata;
   end

   task automatic fill_sram();
      logic [18:0] fa;
      for (int i = 0; i < 524288; i++) begin
         fa = i[18:0];
         sram_mem[fa] <= fa[7:0] ^ fa[15:8] ^ {5'd0, fa[18:16]};
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Expected SRAM addresses from the region layout
   function automatic logic [18:0] page_addr(input logic [4:0] page, input logic [13:0] off);
      return {page, off};
   endfunction

   function automatic logic [18:0] rom_addr(input logic [1:0] sel, input logic [13:0] off);
      return {3'b010, sel, off};
   endfunction

   function automatic logic [18:0] divrom_addr(input logic [12:0] off);
      return {6'b011000, off};
   endfunction

   function automatic logic [18:0] divram_addr(input logic [3:0] page, input logic [12:0] off);
      return {2'b10, page, off};
   endfunction

   task automatic add_row(input string n, input logic [3:0] op, input logic [15:0] a,
                          input logic [7:0] d, input logic [18:0] e);
      row_name.push_back(n);
      row_op.push_back(op);
      row_addr.push_back(a);
      row_data.push_back(d);
      row_exp.push_back(e);
   endtask

   //////////////////////////////////////////////////
   // Stimulus table

   task automatic build_table();
      logic [31:0] rnd;
      logic [1:0]  q;
      logic [13:0] off;
      logic [4:0]  page;
      logic [15:0] cpu_a [8];
      logic [7:0]  byte_v [8];
      logic [18:0] phys [8];
      add_row("reset", OP_RD_DATA, 16'h0123, 8'h00, {11'd0, 8'h23 ^ 8'hA5});
      add_row("reset", OP_RD_ADDR, 16'hC123, 8'h00, page_addr(5'd0, 14'h0123));
      add_row("reset", OP_ZXR, 16'h0000, 8'h00, 19'h01);
      add_row("reset", OP_IDLE, 16'h0000, 8'h00, 19'h3);
      add_row("reset", OP_NMI, 16'h0000, 8'h00, 19'h0);
      add_row("reset", OP_FLAGS, 16'h0000, 8'h00, 19'h1);      // Boot mode only
      add_row("boot mapper", OP_ZXW, 16'h0001, 8'h13, 19'h0);
      add_row("boot mapper", OP_RD_ADDR, 16'hC010, 8'h00, page_addr(5'h13, 14'h0010));
      add_row("boot mapper", OP_ZXR, 16'h0001, 8'h00, 19'h13);
      add_row("leave boot", OP_ZXW, 16'h0000, 8'h02, 19'h0);
      add_row("leave boot", OP_ZXR, 16'h0000, 8'h00, 19'h02);
      add_row("leave boot", OP_FLAGS, 16'h0000, 8'h00, 19'h0);
      add_row("leave boot", OP_ZXW, 16'h0001, 8'h05, 19'h0);   // Mapper now frozen
      add_row("leave boot", OP_ZXR, 16'h0001, 8'h00, 19'h13);
      add_row("paging 128k", OP_IOW, 16'h7FFD, 8'h16, 19'h0);
      add_row("paging 128k", OP_RD_ADDR, 16'hC000, 8'h00, page_addr(5'd6, 14'h0000));
      add_row("paging 128k", OP_RD_ADDR, 16'h0100, 8'h00, rom_addr(2'b01, 14'h0100));
      add_row("paging 128k", OP_RD_ADDR, 16'h4000, 8'h00, page_addr(5'd5, 14'h0000));
      add_row("paging 128k", OP_RD_ADDR, 16'h8000, 8'h00, page_addr(5'd2, 14'h0000));
      add_row("paging 128k", OP_WR, 16'h0100, 8'h55, 19'h1);
      add_row("paging 128k", OP_WR, 16'hC000, 8'h77, 19'h0);
      add_row("port lock", OP_IOW, 16'h7FFD, 8'h23, 19'h0);
      add_row("port lock", OP_RD_ADDR, 16'hC000, 8'h00, page_addr(5'd3, 14'h0000));
      add_row("port lock", OP_IOW, 16'h7FFD, 8'h07, 19'h0);
      add_row("port lock", OP_RD_ADDR, 16'hC000, 8'h00, page_addr(5'd3, 14'h0000));
      add_row("port lock", OP_RD_ADDR, 16'h0000, 8'h00, rom_addr(2'b00, 14'h0000));
      add_row("all ram", OP_SRST, 16'h0000, 8'h00, 19'h0);     // Drops the lock
      for (int arr = 0; arr < 4; arr++) begin
         add_row("all ram", OP_IOW, 16'h1FFD, {5'd0, arr[1:0], 1'b1}, 19'h0);
         for (int qi = 0; qi < 4; qi++)
            add_row("all ram", OP_RD_ADDR, {qi[1:0], 14'h0155}, 8'h00,
                    page_addr({2'b00, plus3_pages[arr * 4 + qi]}, 14'h0155));
      end
      add_row("all ram", OP_IOW, 16'h1FFD, 8'h00, 19'h0);
      add_row("divmmc conmem", OP_IOW, 16'h00E3, 8'h85, 19'h0);
      add_row("divmmc conmem", OP_RD_ADDR, 16'h0100, 8'h00, divrom_addr(13'h0100));
      add_row("divmmc conmem", OP_WR, 16'h0100, 8'h11, 19'h1);
      add_row("divmmc conmem", OP_RD_ADDR, 16'h2100, 8'h00, divram_addr(4'd5, 13'h0100));
      add_row("divmmc conmem", OP_WR, 16'h2100, 8'h22, 19'h0);
      add_row("divmmc conmem", OP_IOW, 16'h00E3, 8'h00, 19'h0);
      add_row("divmmc conmem", OP_RD_ADDR, 16'h0100, 8'h00, rom_addr(2'b00, 14'h0100));
      add_row("automap deferred", OP_NMI, 16'h0000, 8'h00, 19'h0);
      add_row("automap deferred", OP_FETCH, 16'h0038, 8'h00, rom_addr(2'b00, 14'h0038));
      add_row("automap deferred", OP_RD_ADDR, 16'h0038, 8'h00, rom_addr(2'b00, 14'h0038));
      add_row("automap deferred", OP_WAIT_MAP, 16'h0038, 8'h00, divrom_addr(13'h0038));
      add_row("automap deferred", OP_NMI, 16'h0000, 8'h00, 19'h1);
      add_row("divmmc mapram", OP_IOW, 16'h00E3, 8'h43, 19'h0);
      add_row("divmmc mapram", OP_RD_ADDR, 16'h0100, 8'h00, divram_addr(4'd3, 13'h0100));
      add_row("divmmc mapram", OP_WR, 16'h0100, 8'h33, 19'h1);
      add_row("divmmc mapram", OP_RD_ADDR, 16'h2100, 8'h00, divram_addr(4'd3, 13'h0100));
      add_row("divmmc mapram", OP_WR, 16'h2100, 8'h33, 19'h1);
      add_row("divmmc mapram", OP_IOW, 16'h00E3, 8'h44, 19'h0);
      add_row("divmmc mapram", OP_WR, 16'h2100, 8'h44, 19'h0);
      add_row("divmmc mapram", OP_IOW, 16'h00E3, 8'h00, 19'h0);
      add_row("automap unmap", OP_FETCH, 16'h1FF8, 8'h00, divrom_addr(13'h1FF8));
      add_row("automap unmap", OP_RD_ADDR, 16'h0100, 8'h00, divrom_addr(13'h0100));
      add_row("automap unmap", OP_WAIT_MAP, 16'h0100, 8'h00, rom_addr(2'b00, 14'h0100));
      add_row("automap unmap", OP_NMI, 16'h0000, 8'h00, 19'h0);
      add_row("automap immediate", OP_FETCH, 16'h3D00, 8'h00, rom_addr(2'b00, 14'h3D00));
      add_row("automap immediate", OP_RD_ADDR, 16'h3D01, 8'h00, divram_addr(4'd0, 13'h1D01));
      add_row("automap immediate", OP_NMI, 16'h0000, 8'h00, 19'h1);
      add_row("nmi disable", OP_ZXW, 16'h0000, 8'h06, 19'h0);
      add_row("nmi disable", OP_NMI, 16'h0000, 8'h00, 19'h0);
      add_row("nmi disable", OP_ZXW, 16'h0000, 8'h02, 19'h0);
      add_row("master flags", OP_ZXW, 16'h0000, 8'h1A, 19'h0);  // Timing, issue2, DivMMC
      add_row("master flags", OP_FLAGS, 16'h0000, 8'h00, 19'h6);
      add_row("master flags", OP_ZXR, 16'h0000, 8'h00, 19'h02);
      add_row("soft reset", OP_SRST, 16'h0000, 8'h00, 19'h0);
      add_row("soft reset", OP_RD_ADDR, 16'h0100, 8'h00, rom_addr(2'b00, 14'h0100));
      add_row("soft reset", OP_NMI, 16'h0000, 8'h00, 19'h0);
      add_row("soft reset", OP_ZXR, 16'h0000, 8'h00, 19'h02);  // Master config survives
      add_row("soft reset", OP_FLAGS, 16'h0000, 8'h00, 19'h6);
      // Quadrants 1 to 3, low bits keep the addresses distinct
      for (int k = 0; k < 8; k++) begin
         rnd       = take_bits(2);
         q         = (rnd[1:0] == 2'd0) ? 2'd3 : rnd[1:0];
         rnd       = take_bits(11);
         off       = {rnd[10:0], k[2:0]};
         cpu_a[k]  = {q, off};
         rnd       = take_bits(8);
         byte_v[k] = rnd[7:0];
         page      = (q == 2'd1) ? 5'd5 : (q == 2'd2) ? 5'd2 : 5'd0;
         phys[k]   = page_addr(page, off);
         add_row("ram data", OP_WR, cpu_a[k], byte_v[k], 19'h0);
      end
      for (int k = 0; k < 8; k++) begin
         add_row("ram data", OP_RD_DATA, cpu_a[k], 8'h00, {11'd0, byte_v[k]});
         add_row("ram data", OP_MEMCHK, 16'h0000, byte_v[k], phys[k]);
      end
   endtask

   //////////////////////////////////////////////////
   // Row execution and reporting

   task automatic idle_inputs();
      bus.a      = 16'h0000;
      bus.din    = 8'h00;
      bus.mreq_n = 1'b1;
      bus.iorq_n = 1'b1;
      bus.rd_n   = 1'b1;
      bus.wr_n   = 1'b1;
      bus.m1_n   = 1'b1;
      zx_addr    = 8'h00;
      zx_ior     = 1'b0;
      zx_iow     = 1'b0;
      rst_n      = 1'b1;
   endtask

   task automatic run_row(input int i);
      logic [18:0] want;
      logic [18:0] act;
      int          tries;
      @(posedge clk);
      #1;
      idle_inputs();
      bus.a   = row_addr[i];
      bus.din = row_data[i];
      case (row_op[i])
         OP_ZXW: begin
            zx_addr = row_addr[i][7:0];
            zx_iow  = 1'b1;
         end
         OP_ZXR: begin
            zx_addr = row_addr[i][7:0];
            zx_ior  = 1'b1;
         end
         OP_IOW: begin
            bus.iorq_n = 1'b0;
            bus.wr_n   = 1'b0;
         end
         OP_RD_ADDR, OP_RD_DATA, OP_WAIT_MAP: begin
            bus.mreq_n = 1'b0;
            bus.rd_n   = 1'b0;
         end
         OP_WR: begin
            bus.mreq_n = 1'b0;
            bus.wr_n   = 1'b0;
         end
         OP_FETCH: begin
            bus.mreq_n = 1'b0;
            bus.rd_n   = 1'b0;
            bus.m1_n   = 1'b0;
         end
         OP_SRST: rst_n = 1'b0;
         default: ;
      endcase
      @(negedge clk);                     // Outputs settled mid cycle
      want = row_exp[i];
      act  = want;
      case (row_op[i])
         OP_ZXR, OP_RD_DATA:   act = {10'd0, oe_n, dout};
         OP_RD_ADDR, OP_FETCH: act = sram_addr;
         OP_WR:                act = {18'd0, sram_we_n};
         OP_IDLE:              act = {17'd0, oe_n, sram_we_n};
         OP_NMI:               act = {18'd0, enable_nmi};
         OP_FLAGS:             act = {16'd0, timing_ula, issue2_keyboard, boot_mode};
         OP_MEMCHK: begin
            want = {11'd0, row_data[i]};
            act  = {11'd0, sram_mem[row_exp[i]]};
         end
         OP_WAIT_MAP: begin
            tries = 0;
            while (sram_addr !== want && tries < 16) begin
               @(negedge clk);
               tries++;
            end
            if (sram_addr !== want) begin
               $display("timeout in %s: read at %h still maps to %h", row_name[i],
                        row_addr[i], sram_addr);
               test_errs++;
            end
         end
         default: ;
      endcase
      if (act !== want) begin
         $display("error %s: expected %h, actual %h", row_name[i], want, act);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string n);
      tests_run++;
      total_errs += test_errs;
      if (test_errs == 0) begin
         $display("test %-18s ok", n);
      end else begin
         $display("test %-18s failed with %0d errors", n, test_errs);
         tests_failed++;
      end
      test_errs = 0;
   endtask

   initial begin
      mrst_n       = 1'b0;
      test_errs    = 0;
      tests_run    = 0;
      tests_failed = 0;
      total_errs   = 0;
      idle_inputs();
      fill_sram();
      build_table();
      repeat (10) @(posedge clk);
      #1;
      mrst_n = 1'b1;
      for (int i = 0; i < row_op.size(); i++) begin
         if (i > 0 && row_name[i] != row_name[i - 1])
            finish_test(row_name[i - 1]);
         run_row(i);
      end
      finish_test(row_name[row_name.size() - 1]);
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
      if (tests_failed == 0 && total_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/zxmem_pkg.sv
source/cpu_cycle_decode.sv
source/paging_regs.sv
source/divmmc_automap.sv
source/sram_addr_map.sv
source/cpu_read_mux.sv
source/memory_top.sv
tb/tb_memory_top.sv

/* Makefile */
SIM = obj_dir/Vtb_memory_top

$(SIM): sources.f $(wildcard source/*.sv source/*.svh) tb/tb_memory_top.sv
	verilator --binary --top-module tb_memory_top -f sources.f -o Vtb_memory_top

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
